// ==== hw/mem_pkg.sv ====
package mem_pkg;

    // **************************************************
    // data path widths
    // **************************************************
    localparam int XLEN  = 32;
    localparam int ID_W  = 64;
    localparam int REG_W = 5;

    // **************************************************
    // data memory geometry and timing
    // **************************************************
    // word index comes from address bits 9:2
    localparam int MEM_WORDS        = 256;
    localparam int MEM_IDX_W        = $clog2(MEM_WORDS);
    // cycles from an accepted read to its valid pulse
    localparam int MEM_READ_LATENCY = 2;

    // memory command carried by each instruction
    typedef enum logic [3:0] {
        OP_NONE,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_AMOSWAP_W
    } mem_op_e;

    // memory stage FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_READY,
        ST_WAIT_VALID
    } stage_state_e;

endpackage

// ==== hw/issue_reg.sv ====
`timescale 1ns/1ps

module issue_reg
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              stall,

    input  logic              issue_valid,
    input  mem_op_e           issue_op,
    input  logic [REG_W-1:0]  issue_rd,
    input  logic [XLEN-1:0]   issue_addr,
    input  logic [XLEN-1:0]   issue_wdata,
    input  logic [ID_W-1:0]   issue_id,

    output logic              mem_valid,
    output mem_op_e           mem_op,
    output logic [REG_W-1:0]  mem_rd,
    output logic [XLEN-1:0]   mem_alu_out,
    output logic [XLEN-1:0]   mem_rs2_data,
    output logic [ID_W-1:0]   mem_inst_id
);

    // valid drops when nothing new is presented, so a finished op is not rerun
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            mem_valid <= 1'b0;
        end else if (!stall) begin
            mem_valid <= issue_valid;
        end
    end

    // payload frozen while the stage is busy
    always_ff @(posedge clk) begin
        if (!stall && issue_valid) begin
            mem_op       <= issue_op;
            mem_rd       <= issue_rd;
            mem_alu_out  <= issue_addr;
            mem_rs2_data <= issue_wdata;
            mem_inst_id  <= issue_id;
        end
    end

    a_op_held: assert property (@(posedge clk) disable iff (reset)
        stall && mem_valid |=> mem_op == $past(mem_op));

endmodule

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,

    input  logic              mem_valid,
    input  mem_op_e           mem_op,
    input  logic [REG_W-1:0]  mem_rd,
    input  logic [XLEN-1:0]   mem_alu_out,
    input  logic [XLEN-1:0]   mem_rs2_data,
    input  logic [ID_W-1:0]   mem_inst_id,

    output logic              stall,

    output logic              memu_cmd_start,
    output logic              memu_cmd_write,
    output logic [XLEN-1:0]   memu_addr,
    output logic [XLEN-1:0]   memu_wdata,
    output logic [XLEN-1:0]   memu_wmask,
    input  logic              memu_cmd_ready,
    input  logic              memu_valid,
    input  logic [XLEN-1:0]   memu_rdata,

    output logic              stage_done,
    output mem_op_e           done_op,
    output logic [REG_W-1:0]  done_rd,
    output logic [ID_W-1:0]   done_id,
    output logic [XLEN-1:0]   done_alu_out,
    output logic [XLEN-1:0]   done_mem_data
);

    stage_state_e     state;
    // op being issued to memory, amoswap turns into OP_SW after its read
    mem_op_e          cur_op;
    logic             done_flag;
    logic [ID_W-1:0]  done_id_q;
    logic             rd_pending;
    logic             orphan_rd;
    logic [XLEN-1:0]  rdata_q;

    logic             may_start;
    logic             active;
    logic             is_mem;
    logic             wr_accept;
    logic             finish;
    logic [4:0]       byte_shift;
    logic [4:0]       half_shift;
    logic [XLEN-1:0]  ld_byte_word;
    logic [XLEN-1:0]  ld_half_word;

    // same id seen again after finishing means a repeat, not new work
    assign may_start  = !done_flag || (done_id_q != mem_inst_id);
    assign active     = mem_valid && may_start && !flush;
    assign is_mem     = (mem_op != OP_NONE);
    assign byte_shift = {mem_alu_out[1:0], 3'b000};
    assign half_shift = {mem_alu_out[1], 4'b0000};

    // **************************************************
    // memory command
    // **************************************************
    assign memu_cmd_start = active && (state == ST_WAIT_READY) && memu_cmd_ready;
    assign memu_cmd_write = cur_op inside {OP_SB, OP_SH, OP_SW};
    assign memu_addr      = mem_alu_out;
    assign wr_accept      = memu_cmd_start && memu_cmd_write;

    // lane placement of store data
    always_comb begin
        case (cur_op)
            OP_SB: begin
                memu_wdata = {4{mem_rs2_data[7:0]}};
                memu_wmask = XLEN'(32'h0000_00ff) << byte_shift;
            end
            OP_SH: begin
                memu_wdata = {2{mem_rs2_data[15:0]}};
                memu_wmask = XLEN'(32'h0000_ffff) << half_shift;
            end
            default: begin
                memu_wdata = mem_rs2_data;
                memu_wmask = '1;
            end
        endcase
    end

    // **************************************************
    // completion and writeback data
    // **************************************************
    // ALU ops finish on arrival, loads one cycle after their data
    assign finish = active && (((state == ST_IDLE) && (!is_mem || rd_pending)) || wr_accept);
    assign stall  = mem_valid && may_start && is_mem && !finish;

    assign stage_done   = finish;
    assign done_op      = mem_op;
    assign done_rd      = mem_rd;
    assign done_id      = mem_inst_id;
    assign done_alu_out = mem_alu_out;

    assign ld_byte_word = rdata_q >> byte_shift;
    assign ld_half_word = rdata_q >> half_shift;

    always_comb begin
        case (mem_op)
            OP_LB:   done_mem_data = {{24{ld_byte_word[7]}}, ld_byte_word[7:0]};
            OP_LBU:  done_mem_data = {24'b0, ld_byte_word[7:0]};
            OP_LH:   done_mem_data = {{16{ld_half_word[15]}}, ld_half_word[15:0]};
            OP_LHU:  done_mem_data = {16'b0, ld_half_word[15:0]};
            // word load and amoswap old value
            default: done_mem_data = rdata_q;
        endcase
    end

    // **************************************************
    // FSM
    // **************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            cur_op     <= OP_NONE;
            done_flag  <= 1'b0;
            rd_pending <= 1'b0;
        end else if (flush) begin
            state      <= ST_IDLE;
            cur_op     <= OP_NONE;
            rd_pending <= 1'b0;
        end else begin
            if (finish) begin
                done_flag  <= 1'b1;
                rd_pending <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (active && is_mem && !rd_pending) begin
                        state  <= ST_WAIT_READY;
                        cur_op <= mem_op;
                    end
                end
                ST_WAIT_READY: begin
                    if (memu_cmd_start) begin
                        state <= memu_cmd_write ? ST_IDLE : ST_WAIT_VALID;
                    end
                end
                ST_WAIT_VALID: begin
                    if (memu_valid) begin
                        if (cur_op == OP_AMOSWAP_W) begin
                            // read done, now write the new word
                            cur_op <= OP_SW;
                            state  <= ST_WAIT_READY;
                        end else begin
                            state      <= ST_IDLE;
                            rd_pending <= 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            done_id_q <= mem_inst_id;
        end
        if ((state == ST_WAIT_VALID) && memu_valid) begin
            rdata_q <= memu_rdata;
        end
    end

    // a read killed by flush still owes its valid pulse
    always_ff @(posedge clk) begin
        if (reset) begin
            orphan_rd <= 1'b0;
        end else if (memu_valid) begin
            orphan_rd <= 1'b0;
        end else if (flush && (state == ST_WAIT_VALID)) begin
            orphan_rd <= 1'b1;
        end
    end

    a_no_start_wait_valid: assert property (@(posedge clk) disable iff (reset)
        memu_cmd_start |-> state != ST_WAIT_VALID);

    a_valid_expected: assert property (@(posedge clk) disable iff (reset)
        memu_valid && (state == ST_IDLE) |-> orphan_rd);

endmodule

// ==== hw/data_mem_unit.sv ====
`timescale 1ns/1ps

module data_mem_unit
    import mem_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             cmd_start,
    input  logic             cmd_write,
    input  logic [XLEN-1:0]  addr,
    input  logic [XLEN-1:0]  wdata,
    input  logic [XLEN-1:0]  wmask,
    output logic             cmd_ready,
    output logic             rdata_valid,
    output logic [XLEN-1:0]  rdata
);

    logic [XLEN-1:0]              mem [MEM_WORDS];
    logic [MEM_IDX_W-1:0]         idx;
    logic [MEM_IDX_W-1:0]         clr_idx;
    logic                         clearing;
    logic [MEM_READ_LATENCY-1:0]  rd_pipe;
    logic                         accept;

    assign idx         = addr[MEM_IDX_W+1:2];
    // busy while clearing or while a read is in the pipe
    assign cmd_ready   = !clearing && (rd_pipe == '0);
    assign accept      = cmd_start && cmd_ready;
    assign rdata_valid = rd_pipe[MEM_READ_LATENCY-1];

    // clear sequencer and read latency pipe
    always_ff @(posedge clk) begin
        if (reset) begin
            clearing <= 1'b1;
            clr_idx  <= '0;
            rd_pipe  <= '0;
        end else begin
            if (clearing) begin
                clr_idx <= clr_idx + 1'b1;
                if (clr_idx == MEM_IDX_W'(MEM_WORDS - 1)) begin
                    clearing <= 1'b0;
                end
            end
            rd_pipe <= (rd_pipe << 1) | MEM_READ_LATENCY'(accept && !cmd_write);
        end
    end

    // **************************************************
    // storage
    // **************************************************
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clr_idx] <= '0;
        end else if (accept && cmd_write) begin
            // merge only the enabled bytes
            mem[idx] <= (mem[idx] & ~wmask) | (wdata & wmask);
        end
    end

    // word captured at accept, held until the valid pulse
    always_ff @(posedge clk) begin
        if (accept && !cmd_write) begin
            rdata <= mem[idx];
        end
    end

    a_start_when_ready: assert property (@(posedge clk) disable iff (reset)
        cmd_start |-> cmd_ready);

endmodule

// ==== hw/wb_reg.sv ====
`timescale 1ns/1ps

module wb_reg
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              stage_done,
    input  mem_op_e           done_op,
    input  logic [REG_W-1:0]  done_rd,
    input  logic [ID_W-1:0]   done_id,
    input  logic [XLEN-1:0]   done_alu_out,
    input  logic [XLEN-1:0]   done_mem_data,
    output logic              wb_valid,
    output logic [REG_W-1:0]  wb_rd,
    output logic [ID_W-1:0]   wb_id,
    output logic [XLEN-1:0]   wb_data
);

    logic is_store;
    logic use_mem;

    assign is_store = done_op inside {OP_SB, OP_SH, OP_SW};
    // loads and amoswap return memory data
    assign use_mem  = done_op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_AMOSWAP_W};

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= stage_done;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_done) begin
            wb_id   <= done_id;
            // stores have no destination register
            wb_rd   <= is_store ? '0 : done_rd;
            wb_data <= use_mem ? done_mem_data : done_alu_out;
        end
    end

endmodule

// ==== hw/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              issue_valid,
    input  mem_op_e           issue_op,
    input  logic [REG_W-1:0]  issue_rd,
    input  logic [XLEN-1:0]   issue_addr,
    input  logic [XLEN-1:0]   issue_wdata,
    input  logic [ID_W-1:0]   issue_id,
    output logic              issue_stall,
    output logic              wb_valid,
    output logic [REG_W-1:0]  wb_rd,
    output logic [ID_W-1:0]   wb_id,
    output logic [XLEN-1:0]   wb_data
);

    // issue register to stage
    logic              mem_valid;
    mem_op_e           mem_op;
    logic [REG_W-1:0]  mem_rd;
    logic [XLEN-1:0]   mem_alu_out;
    logic [XLEN-1:0]   mem_rs2_data;
    logic [ID_W-1:0]   mem_inst_id;

    // stage to memory unit
    logic              memu_cmd_start;
    logic              memu_cmd_write;
    logic [XLEN-1:0]   memu_addr;
    logic [XLEN-1:0]   memu_wdata;
    logic [XLEN-1:0]   memu_wmask;
    logic              memu_cmd_ready;
    logic              memu_valid;
    logic [XLEN-1:0]   memu_rdata;

    // stage to writeback
    logic              stage_done;
    mem_op_e           done_op;
    logic [REG_W-1:0]  done_rd;
    logic [ID_W-1:0]   done_id;
    logic [XLEN-1:0]   done_alu_out;
    logic [XLEN-1:0]   done_mem_data;

    issue_reg u_issue_reg (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .stall        (issue_stall),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_rd     (issue_rd),
        .issue_addr   (issue_addr),
        .issue_wdata  (issue_wdata),
        .issue_id     (issue_id),
        .mem_valid    (mem_valid),
        .mem_op       (mem_op),
        .mem_rd       (mem_rd),
        .mem_alu_out  (mem_alu_out),
        .mem_rs2_data (mem_rs2_data),
        .mem_inst_id  (mem_inst_id)
    );

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .mem_valid      (mem_valid),
        .mem_op         (mem_op),
        .mem_rd         (mem_rd),
        .mem_alu_out    (mem_alu_out),
        .mem_rs2_data   (mem_rs2_data),
        .mem_inst_id    (mem_inst_id),
        .stall          (issue_stall),
        .memu_cmd_start (memu_cmd_start),
        .memu_cmd_write (memu_cmd_write),
        .memu_addr      (memu_addr),
        .memu_wdata     (memu_wdata),
        .memu_wmask     (memu_wmask),
        .memu_cmd_ready (memu_cmd_ready),
        .memu_valid     (memu_valid),
        .memu_rdata     (memu_rdata),
        .stage_done     (stage_done),
        .done_op        (done_op),
        .done_rd        (done_rd),
        .done_id        (done_id),
        .done_alu_out   (done_alu_out),
        .done_mem_data  (done_mem_data)
    );

    data_mem_unit u_data_mem_unit (
        .clk         (clk),
        .reset       (reset),
        .cmd_start   (memu_cmd_start),
        .cmd_write   (memu_cmd_write),
        .addr        (memu_addr),
        .wdata       (memu_wdata),
        .wmask       (memu_wmask),
        .cmd_ready   (memu_cmd_ready),
        .rdata_valid (memu_valid),
        .rdata       (memu_rdata)
    );

    wb_reg u_wb_reg (
        .clk           (clk),
        .reset         (reset),
        .stage_done    (stage_done),
        .done_op       (done_op),
        .done_rd       (done_rd),
        .done_id       (done_id),
        .done_alu_out  (done_alu_out),
        .done_mem_data (done_mem_data),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_id         (wb_id),
        .wb_data       (wb_data)
    );

    // while the stage waits for read data the unit must still be busy
    a_wait_valid_busy: assert property (@(posedge clk) disable iff (reset)
        (u_mem_stage.state == ST_WAIT_VALID) |-> !memu_cmd_ready);

endmodule

// ==== bench/mem_subsys_tb.sv ====
`timescale 1ns/1ps

module mem_subsys_tb
    import mem_pkg::*;
();

    logic              clk = 1'b0;
    logic              reset;
    logic              flush;
    logic              issue_valid;
    mem_op_e           issue_op;
    logic [REG_W-1:0]  issue_rd;
    logic [XLEN-1:0]   issue_addr;
    logic [XLEN-1:0]   issue_wdata;
    logic [ID_W-1:0]   issue_id;
    logic              issue_stall;
    logic              wb_valid;
    logic [REG_W-1:0]  wb_rd;
    logic [ID_W-1:0]   wb_id;
    logic [XLEN-1:0]   wb_data;

    // one entry per vector line
    logic              vec_flush [$];
    logic [3:0]        vec_op [$];
    logic [REG_W-1:0]  vec_rd [$];
    logic [XLEN-1:0]   vec_addr [$];
    logic [XLEN-1:0]   vec_wdata [$];
    logic [REG_W-1:0]  vec_exp_rd [$];
    logic [XLEN-1:0]   vec_exp_data [$];

    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;
    int                cycle_limit = 0;
    logic [ID_W-1:0]   next_id = 64'h100;

    mem_subsys_top u_mem_subsys_top (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_rd    (issue_rd),
        .issue_addr  (issue_addr),
        .issue_wdata (issue_wdata),
        .issue_id    (issue_id),
        .issue_stall (issue_stall),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_id       (wb_id),
        .wb_data     (wb_data)
    );

    always #4 clk = ~clk;

    // run limit, counted from time zero
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
            $display("Timeout after %0d cycles, no writeback arrived", cycles);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Some tests failed");
            $finish;
        end
    end

    // **************************************************
    // helpers
    // **************************************************
    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at time %0t: %s is %h, expected %h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic load_vectors(output int count);
        int               fd;
        int               ch;
        int               code;
        int               op_v;
        int               rd_v;
        int               exp_rd_v;
        logic [39:0]      kind;
        logic [XLEN-1:0]  addr_v;
        logic [XLEN-1:0]  wdata_v;
        logic [XLEN-1:0]  exp_data_v;
        count = 0;
        fd = $fopen("bench/mem_input.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open bench/mem_input.txt");
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == {32'b0, "#"}) begin
                    // skip the rest of a comment line
                    ch = $fgetc(fd);
                    while ((ch != 10) && (ch != -1)) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    code = $fscanf(fd, "%d %d %h %h %d %h", op_v, rd_v, addr_v,
                                   wdata_v, exp_rd_v, exp_data_v);
                    if ((code != 6) || ((kind != "issue") && (kind != "flush"))) begin
                        errors++;
                        $display("Error: malformed line after vector %0d", count);
                    end else begin
                        vec_flush.push_back(kind == "flush");
                        vec_op.push_back(4'(op_v));
                        vec_rd.push_back(REG_W'(rd_v));
                        vec_addr.push_back(addr_v);
                        vec_wdata.push_back(wdata_v);
                        vec_exp_rd.push_back(REG_W'(exp_rd_v));
                        vec_exp_data.push_back(exp_data_v);
                        count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic present(input int i);
        issue_valid = 1'b1;
        issue_op    = mem_op_e'(vec_op[i]);
        issue_rd    = vec_rd[i];
        issue_addr  = vec_addr[i];
        issue_wdata = vec_wdata[i];
        issue_id    = next_id;
    endtask

    // **************************************************
    // one instruction per vector
    // **************************************************
    task automatic run_issue(input int i);
        @(negedge clk);
        present(i);
        @(negedge clk);
        // memory ops stall from the cycle they arrive, ALU ops finish at once
        check_value("issue_stall", 64'(issue_stall),
                    64'(mem_op_e'(vec_op[i]) != OP_NONE));
        // hold the instruction while the stage is busy
        while (issue_stall) begin
            @(negedge clk);
        end
        issue_valid = 1'b0;
        while (!wb_valid) begin
            @(negedge clk);
        end
        check_value("wb_rd", 64'(wb_rd), 64'(vec_exp_rd[i]));
        check_value("wb_data", 64'(wb_data), 64'(vec_exp_data[i]));
        check_value("wb_id", wb_id, next_id);
        next_id = next_id + 1;
    endtask

    task automatic run_flush(input int i);
        bit seen;
        seen = 1'b0;
        @(negedge clk);
        present(i);
        // issue capture, ST_IDLE, then command accept
        repeat (3) begin
            @(negedge clk);
        end
        flush       = 1'b1;
        issue_valid = 1'b0;
        @(negedge clk);
        flush = 1'b0;
        // orphan read returns in here
        repeat (MEM_READ_LATENCY + 4) begin
            seen = seen | wb_valid;
            @(negedge clk);
        end
        checks++;
        if (seen) begin
            errors++;
            $display("Error at time %0t: flushed instruction %0h still wrote back",
                     $time, next_id);
        end
        next_id = next_id + 1;
    endtask

    initial begin
        int n;
        reset       = 1'b1;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = OP_NONE;
        issue_rd    = '0;
        issue_addr  = '0;
        issue_wdata = '0;
        issue_id    = '0;
        load_vectors(n);
        if (n == 0) begin
            $display("No vectors could be read, nothing was tested");
            $display("Some tests failed");
            $finish;
        end else begin
            cycle_limit = 40 * n + 100;
            repeat (8) begin
                @(negedge clk);
            end
            reset = 1'b0;
            for (int i = 0; i < n; i++) begin
                if (vec_flush[i]) begin
                    run_flush(i);
                end else begin
                    run_issue(i);
                end
            end
            @(negedge clk);
            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
            $finish;
        end
    end

endmodule

// ==== bench/mem_input.txt ====
# kind op rd addr wdata exp_rd exp_data   (addr, wdata, exp_data in hex)
# op: 0 none 1 lb 2 lbu 3 lh 4 lhu 5 lw 6 sb 7 sh 8 sw 9 amoswap.w
# store word then load word back
issue 8 1 00000040 11223344 0 00000040
issue 5 2 00000040 00000000 2 11223344
# byte and half merge into a preset word
issue 8 3 00000080 a1b2c3d4 0 00000080
issue 6 4 00000081 123456ee 0 00000081
issue 7 5 00000082 abcd5566 0 00000082
issue 5 6 00000080 00000000 6 5566eed4
# sign and zero extension
issue 8 7 000000c0 7ff19c80 0 000000c0
issue 1 8 000000c0 00000000 8 ffffff80
issue 2 9 000000c0 00000000 9 00000080
issue 1 10 000000c1 00000000 10 ffffff9c
issue 1 11 000000c3 00000000 11 0000007f
issue 2 12 000000c2 00000000 12 000000f1
issue 3 13 000000c0 00000000 13 ffff9c80
issue 4 14 000000c0 00000000 14 00009c80
issue 3 15 000000c2 00000000 15 00007ff1
issue 4 16 000000c2 00000000 16 00007ff1
# swap, alu pass-through, flush
issue 9 17 00000040 deadbeef 17 11223344
issue 5 18 00000040 00000000 18 deadbeef
issue 0 19 12345678 ffffffff 19 12345678
flush 5 20 00000080 00000000 0 00000000
issue 5 21 00000080 00000000 21 5566eed4
issue 5 22 000003fc 00000000 22 00000000

// ==== project.f ====
hw/mem_pkg.sv
hw/issue_reg.sv
hw/mem_stage.sv
hw/data_mem_unit.sv
hw/wb_reg.sv
hw/mem_subsys_top.sv
bench/mem_subsys_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --sv --timing --assert -Wno-fatal
TOP       = mem_subsys_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = All tests passed
FAIL_MSG  = Some tests failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
